// File: win_buf_config.svh
`ifndef WIN_BUF_CONFIG_SVH
`define WIN_BUF_CONFIG_SVH

// image size in pixels.
`define WB_IMG_W 20
`define WB_IMG_H 16

// window side, rows and columns.
`define WB_WIN 13

// bits per pixel.
`define WB_PIX_W 8

// coordinate widths, must hold WB_IMG_W and WB_IMG_H.
`define WB_COL_W 5
`define WB_ROW_W 5

`endif

// File: win_buf_pkg.sv
`include "win_buf_config.svh"

package win_buf_pkg;

    typedef logic [`WB_PIX_W-1:0] pix_t;
    typedef logic [`WB_COL_W-1:0] col_t;
    typedef logic [`WB_ROW_W-1:0] row_t;

    // frame and row sequencing states.
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        START      = 3'd1,
        START_COL  = 3'd2,
        COL_OUT    = 3'd3,
        END_COL    = 3'd4,
        END_COL_2  = 3'd5,
        FINISH_ALL = 3'd6,
        DONE       = 3'd7
    } win_ctrl_state_e;

endpackage

// File: win_buf_ctrl.sv
`timescale 1ns/100ps

module win_buf_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic layer_done,
    input  logic row_eq_max,
    input  logic col_eq_max,
    input  logic col_ge_threshold,
    output logic count_en,
    output logic frame_clear,
    output logic window_valid,
    output logic frame_done
);
    import win_buf_pkg::*;

    win_ctrl_state_e state;
    win_ctrl_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (layer_done) begin
                    state_next = START;
                end
            end
            START: state_next = START_COL;
            // fill the left part of the window.
            START_COL: begin
                if (col_ge_threshold) begin
                    state_next = COL_OUT;
                end
            end
            COL_OUT: begin
                if (col_eq_max) begin
                    state_next = END_COL;
                end
            end
            END_COL: state_next = row_eq_max ? FINISH_ALL : END_COL_2;
            END_COL_2: state_next = row_eq_max ? FINISH_ALL : START_COL;
            FINISH_ALL: state_next = DONE;
            DONE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // moore outputs.
    always_comb begin
        count_en     = 1'b0;
        frame_clear  = 1'b0;
        window_valid = 1'b0;
        frame_done   = 1'b0;
        case (state)
            START: frame_clear = 1'b1;
            START_COL: count_en = 1'b1;
            COL_OUT: begin
                count_en     = 1'b1;
                window_valid = 1'b1;
            end
            // last window of the row, no fetch.
            END_COL: window_valid = 1'b1;
            FINISH_ALL: frame_done = 1'b1;
            default: begin
                count_en = 1'b0;
            end
        endcase
    end

endmodule

// File: win_buf_counter.sv
`timescale 1ns/100ps

`include "win_buf_config.svh"

module win_buf_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              count_en,
    input  logic              frame_clear,
    output win_buf_pkg::row_t pix_row,
    output win_buf_pkg::col_t pix_col,
    output logic              row_eq_max,
    output logic              col_eq_max,
    output logic              col_ge_threshold
);
    import win_buf_pkg::*;

    localparam col_t LAST_COL  = col_t'(`WB_IMG_W - 1);
    localparam col_t THRESHOLD = col_t'(`WB_WIN - 1);
    localparam row_t ROW_MAX   = row_t'(`WB_IMG_H);

    // column position, wraps at the end of the row.
    always_ff @(posedge clk) begin
        if (!rst_n || frame_clear) begin
            pix_col <= '0;
        end else if (count_en) begin
            if (col_eq_max) begin
                pix_col <= '0;
            end else begin
                pix_col <= pix_col + col_t'(1);
            end
        end
    end

    // row position, steps on each column wrap.
    always_ff @(posedge clk) begin
        if (!rst_n || frame_clear) begin
            pix_row <= '0;
        end else if (count_en && col_eq_max) begin
            pix_row <= pix_row + row_t'(1);
        end
    end

    // row_eq_max means every row has been read.
    always_comb begin
        row_eq_max       = (pix_row == ROW_MAX);
        col_eq_max       = (pix_col == LAST_COL);
        col_ge_threshold = (pix_col >= THRESHOLD);
    end

endmodule

// File: win_line_buffer.sv
`timescale 1ns/100ps

`include "win_buf_config.svh"

module win_line_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          shift_en,
    input  logic                          frame_clear,
    input  win_buf_pkg::col_t             pix_col,
    input  win_buf_pkg::pix_t             pix_in,
    output logic [`WB_WIN*`WB_PIX_W-1:0]  col_out
);
    import win_buf_pkg::*;

    localparam int unsigned NUM_LINES = `WB_WIN - 1;

    // line 0 is the oldest row, NUM_LINES-1 the row just above pix_in.
    pix_t line_mem [NUM_LINES][`WB_IMG_W];

    always_ff @(posedge clk) begin
        if (!rst_n || frame_clear) begin
            // zero rows stand in for padding above the image.
            for (int k = 0; k < NUM_LINES; k++) begin
                for (int x = 0; x < `WB_IMG_W; x++) begin
                    line_mem[k][x] <= '0;
                end
            end
        end else if (shift_en) begin
            for (int k = 0; k < NUM_LINES - 1; k++) begin
                line_mem[k][pix_col] <= line_mem[k+1][pix_col];
            end
            line_mem[NUM_LINES-1][pix_col] <= pix_in;
        end
    end

    // vertical column at pix_col, oldest first.
    always_comb begin
        for (int k = 0; k < NUM_LINES; k++) begin
            col_out[k*`WB_PIX_W +: `WB_PIX_W] = line_mem[k][pix_col];
        end
        col_out[NUM_LINES*`WB_PIX_W +: `WB_PIX_W] = pix_in;
    end

endmodule

// File: win_shift_array.sv
`timescale 1ns/100ps

`include "win_buf_config.svh"

module win_shift_array (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  shift_en,
    input  logic                                  frame_clear,
    input  logic [`WB_WIN*`WB_PIX_W-1:0]          col_in,
    output logic [`WB_WIN*`WB_WIN*`WB_PIX_W-1:0]  window
);
    import win_buf_pkg::*;

    localparam int unsigned LAST = `WB_WIN - 1;

    // win_q[i][j], i is the row, j the column; j = LAST is the newest.
    pix_t win_q [`WB_WIN][`WB_WIN];

    always_ff @(posedge clk) begin
        if (!rst_n || frame_clear) begin
            for (int i = 0; i < `WB_WIN; i++) begin
                for (int j = 0; j < `WB_WIN; j++) begin
                    win_q[i][j] <= '0;
                end
            end
        end else if (shift_en) begin
            for (int i = 0; i < `WB_WIN; i++) begin
                for (int j = 0; j < LAST; j++) begin
                    win_q[i][j] <= win_q[i][j+1];
                end
                win_q[i][LAST] <= col_in[i*`WB_PIX_W +: `WB_PIX_W];
            end
        end
    end

    // flatten row-major, element (i, j) at index i*WB_WIN + j.
    always_comb begin
        for (int i = 0; i < `WB_WIN; i++) begin
            for (int j = 0; j < `WB_WIN; j++) begin
                window[(i*`WB_WIN + j)*`WB_PIX_W +: `WB_PIX_W] = win_q[i][j];
            end
        end
    end

endmodule

// File: win_buf_top.sv
`timescale 1ns/100ps

`include "win_buf_config.svh"

module win_buf_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  layer_done,
    input  win_buf_pkg::pix_t                     pix_data,
    output logic                                  pix_rd_en,
    output win_buf_pkg::row_t                     pix_row,
    output win_buf_pkg::col_t                     pix_col,
    output logic [`WB_WIN*`WB_WIN*`WB_PIX_W-1:0]  window,
    output logic                                  window_valid,
    output logic                                  frame_done
);

    logic                          count_en;
    logic                          frame_clear;
    logic                          row_eq_max;
    logic                          col_eq_max;
    logic                          col_ge_threshold;
    logic [`WB_WIN*`WB_PIX_W-1:0]  col_data;

    // one pixel is consumed per cycle while count_en is high.
    assign pix_rd_en = count_en;

    win_buf_ctrl u_win_buf_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .layer_done       (layer_done),
        .row_eq_max       (row_eq_max),
        .col_eq_max       (col_eq_max),
        .col_ge_threshold (col_ge_threshold),
        .count_en         (count_en),
        .frame_clear      (frame_clear),
        .window_valid     (window_valid),
        .frame_done       (frame_done)
    );

    win_buf_counter u_win_buf_counter (
        .clk              (clk),
        .rst_n            (rst_n),
        .count_en         (count_en),
        .frame_clear      (frame_clear),
        .pix_row          (pix_row),
        .pix_col          (pix_col),
        .row_eq_max       (row_eq_max),
        .col_eq_max       (col_eq_max),
        .col_ge_threshold (col_ge_threshold)
    );

    win_line_buffer u_win_line_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .shift_en    (count_en),
        .frame_clear (frame_clear),
        .pix_col     (pix_col),
        .pix_in      (pix_data),
        .col_out     (col_data)
    );

    win_shift_array u_win_shift_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .shift_en    (count_en),
        .frame_clear (frame_clear),
        .col_in      (col_data),
        .window      (window)
    );

endmodule

// File: tb_win_buf.sv
`timescale 1ns/100ps

`include "win_buf_config.svh"

module tb_win_buf;
    import win_buf_pkg::*;

    localparam int IMG_W         = `WB_IMG_W;
    localparam int IMG_H         = `WB_IMG_H;
    localparam int WIN           = `WB_WIN;
    localparam int PIX_W         = `WB_PIX_W;
    localparam int WIN_PER_ROW   = IMG_W - WIN + 1;
    localparam int WIN_PER_FRAME = WIN_PER_ROW * IMG_H;
    localparam int NUM_CASES     = 4;
    // frame length and per-case overhead plus the reset phase.
    localparam int CYCLE_LIMIT   = NUM_CASES * (IMG_H * (IMG_W + 2) + 40) + 20;
    localparam int PAT_RANDOM    = 0;
    localparam int PAT_RAMP      = 1;
    localparam int PAT_CONST     = 2;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         layer_done;
    pix_t                         pix_data;
    logic                         pix_rd_en;
    row_t                         pix_row;
    col_t                         pix_col;
    logic [WIN*WIN*PIX_W-1:0]     window;
    logic                         window_valid;
    logic                         frame_done;

    pix_t   frame_mem [IMG_H][IMG_W];
    int     case_pattern [NUM_CASES] = '{PAT_RANDOM, PAT_RAMP, PAT_CONST, PAT_RANDOM};
    int     case_fill    [NUM_CASES] = '{0, 0, 8'hff, 0};
    int     case_windows [NUM_CASES] = '{WIN_PER_FRAME, WIN_PER_FRAME, WIN_PER_FRAME,
                                         WIN_PER_FRAME};
    int     case_done    [NUM_CASES] = '{1, 1, 1, 1};
    integer seed = 32'h6e4c;
    int     value_errors = 0;
    int     count_errors = 0;
    int     cycle_count = 0;

    // per-frame monitor state.
    int     exp_rd_row;
    int     exp_rd_col;
    int     rd_count;
    int     win_count;
    int     done_count;
    int     last_row;
    int     last_col;
    int     row_win_cnt [IMG_H];
    logic   done_seen;

    win_buf_top u_win_buf_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .layer_done   (layer_done),
        .pix_data     (pix_data),
        .pix_rd_en    (pix_rd_en),
        .pix_row      (pix_row),
        .pix_col      (pix_col),
        .window       (window),
        .window_valid (window_valid),
        .frame_done   (frame_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a frame never completed", cycle_count);
            $display("errors: value %0d, count %0d", value_errors, count_errors);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic fill_frame(int pattern, int fill);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (pattern == PAT_RANDOM) begin
                    frame_mem[r][c] = pix_t'($random(seed));
                end else if (pattern == PAT_RAMP) begin
                    frame_mem[r][c] = pix_t'(r * IMG_W + c);
                end else begin
                    frame_mem[r][c] = pix_t'(fill);
                end
            end
        end
    endtask

    // pixel store answers the current address.
    task automatic drive_pixel();
        if (pix_row < IMG_H && pix_col < IMG_W) begin
            pix_data = frame_mem[pix_row][pix_col];
        end else begin
            pix_data = '0;
        end
    endtask

    task automatic reset_monitor();
        exp_rd_row = 0;
        exp_rd_col = 0;
        rd_count   = 0;
        win_count  = 0;
        done_count = 0;
        last_row   = -1;
        last_col   = -1;
        done_seen  = 1'b0;
        for (int r = 0; r < IMG_H; r++) begin
            row_win_cnt[r] = 0;
        end
    endtask

    task automatic check_idle();
        assert (pix_rd_en === 1'b0) else begin
            count_errors++;
            $display("[FAIL] pix_rd_en: expected 0, got %h", pix_rd_en);
        end
        assert (window_valid === 1'b0) else begin
            count_errors++;
            $display("[FAIL] window_valid: expected 0, got %h", window_valid);
        end
        assert (frame_done === 1'b0) else begin
            count_errors++;
            $display("[FAIL] frame_done: expected 0, got %h", frame_done);
        end
    endtask

    // reference window with newest pixel at (r, c) and zeros above the image.
    task automatic check_window(int r, int c);
        logic [WIN*WIN*PIX_W-1:0] exp_win;
        int   rr;
        int   idx;
        logic found;
        exp_win = '0;
        found   = 1'b0;
        for (int i = 0; i < WIN; i++) begin
            for (int j = 0; j < WIN; j++) begin
                rr = r - (WIN - 1) + i;
                if (rr >= 0) begin
                    exp_win[(i*WIN + j)*PIX_W +: PIX_W] = frame_mem[rr][c - (WIN - 1) + j];
                end
            end
        end
        assert (window === exp_win) else begin
            value_errors++;
            for (int i = 0; i < WIN; i++) begin
                for (int j = 0; j < WIN; j++) begin
                    idx = (i*WIN + j)*PIX_W;
                    if (!found && window[idx +: PIX_W] !== exp_win[idx +: PIX_W]) begin
                        found = 1'b1;
                        $display("[FAIL] window[%0d][%0d] at (%0d,%0d): expected %h, got %h",
                                 i, j, r, c, exp_win[idx +: PIX_W], window[idx +: PIX_W]);
                    end
                end
            end
        end
    endtask

    // one sample per falling edge before the next pixel is driven.
    task automatic monitor_cycle();
        int er;
        int ec;
        if (window_valid) begin
            er = win_count / WIN_PER_ROW;
            ec = (WIN - 1) + win_count % WIN_PER_ROW;
            assert (!done_seen) else begin
                count_errors++;
                $display("window_valid seen after frame_done");
            end
            assert (win_count < WIN_PER_FRAME) else begin
                count_errors++;
                $display("more windows than a frame holds");
            end
            assert (last_row == er && last_col == ec) else begin
                count_errors++;
                $display("window %0d shown after reading (%0d,%0d), expected (%0d,%0d)",
                         win_count, last_row, last_col, er, ec);
            end
            if (last_row >= 0 && last_row < IMG_H) begin
                row_win_cnt[last_row]++;
            end
            if (win_count < WIN_PER_FRAME) begin
                check_window(er, ec);
            end
            win_count++;
        end
        if (frame_done) begin
            done_count++;
            assert (win_count == WIN_PER_FRAME) else begin
                count_errors++;
                $display("frame_done came after only %0d windows", win_count);
            end
            done_seen = 1'b1;
        end
        if (pix_rd_en) begin
            assert (rd_count < IMG_W * IMG_H && !done_seen) else begin
                count_errors++;
                $display("pixel read outside the frame");
            end
            assert (pix_row == row_t'(exp_rd_row)) else begin
                value_errors++;
                $display("[FAIL] pix_row: expected %h, got %h", row_t'(exp_rd_row), pix_row);
            end
            assert (pix_col == col_t'(exp_rd_col)) else begin
                value_errors++;
                $display("[FAIL] pix_col: expected %h, got %h", col_t'(exp_rd_col), pix_col);
            end
            last_row = pix_row;
            last_col = pix_col;
            rd_count++;
            exp_rd_col++;
            if (exp_rd_col == IMG_W) begin
                exp_rd_col = 0;
                exp_rd_row++;
            end
        end
        drive_pixel();
    endtask

    task automatic run_case(int idx);
        fill_frame(case_pattern[idx], case_fill[idx]);
        reset_monitor();
        // nothing may move before layer_done.
        repeat (3) begin
            @(negedge clk);
            check_idle();
            drive_pixel();
        end
        layer_done = 1'b1;
        @(negedge clk);
        layer_done = 1'b0;
        monitor_cycle();
        while (!done_seen) begin
            @(negedge clk);
            monitor_cycle();
        end
        repeat (4) begin
            @(negedge clk);
            monitor_cycle();
        end
        assert (win_count == case_windows[idx]) else begin
            count_errors++;
            $display("case %0d gave %0d windows, expected %0d", idx, win_count,
                     case_windows[idx]);
        end
        assert (done_count == case_done[idx]) else begin
            count_errors++;
            $display("case %0d saw frame_done for %0d cycles", idx, done_count);
        end
        assert (rd_count == IMG_W * IMG_H) else begin
            count_errors++;
            $display("case %0d read %0d pixels", idx, rd_count);
        end
        for (int r = 0; r < IMG_H; r++) begin
            assert (row_win_cnt[r] == WIN_PER_ROW) else begin
                count_errors++;
                $display("case %0d row %0d gave %0d windows", idx, r, row_win_cnt[r]);
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        layer_done = 1'b0;
        pix_data   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(k);
        end
        $display("errors: value %0d, count %0d", value_errors, count_errors);
        if (value_errors == 0 && count_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
win_buf_pkg.sv
win_buf_ctrl.sv
win_buf_counter.sv
win_line_buffer.sv
win_shift_array.sv
win_buf_top.sv
tb_win_buf.sv

// File: Bender.yml
package:
  name: win_buf

sources:
  - include_dirs:
      - .
    files:
      - win_buf_pkg.sv
      - win_buf_ctrl.sv
      - win_buf_counter.sv
      - win_line_buffer.sv
      - win_shift_array.sv
      - win_buf_top.sv
      - target: test
        files:
          - tb_win_buf.sv
